// File: verilog/memory_game_pkg.sv
package memory_game_pkg;

    // 640x480 at 60 Hz, counted in pixel clocks
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    typedef logic [9:0] coord_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Tile size in half-resolution pixels
    localparam int TILE_W   = 80;
    localparam int TILE_H   = 60;
    localparam int GRID_DIM = 4;
    localparam int N_CARDS  = GRID_DIM * GRID_DIM;

    typedef logic [3:0]         card_idx_t;
    typedef logic [N_CARDS-1:0] card_vec_t;
    typedef logic [2:0]         pic_t;

    typedef enum logic [1:0] {INIT, SHOW, PLAY, DONE} phase_t;

    typedef enum logic [1:0] {MOVE_PAIR, MOVE_FLIP, MOVE_ENTER} move_kind_t;

    typedef logic [7:0] scan_t;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V
    localparam scan_t CARD_CODES [N_CARDS] = '{
        8'h16, 8'h1E, 8'h26, 8'h25,
        8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

    localparam scan_t CODE_SHIFT = 8'h12;
    localparam scan_t CODE_ENTER = 8'h5A;

    // Cards 0, 1, 13 and 14 start upside down
    localparam card_vec_t PRESET_FLIP = 16'h6003;

    // red, green, blue, yellow, cyan, magenta, white, orange
    localparam rgb_t PALETTE [8] = '{
        '{4'hF, 4'h0, 4'h0}, '{4'h0, 4'hF, 4'h0},
        '{4'h0, 4'h0, 4'hF}, '{4'hF, 4'hF, 4'h0},
        '{4'h0, 4'hF, 4'hF}, '{4'hF, 4'h0, 4'hF},
        '{4'hF, 4'hF, 4'hF}, '{4'hF, 4'h8, 4'h0}
    };

endpackage

// File: verilog/game_ifs.sv
`timescale 1ns/1ps

// Decoded player move, single-cycle strobe
interface key_evt_if;
    import memory_game_pkg::*;

    logic       valid;
    move_kind_t kind;
    card_idx_t  card_a;
    card_idx_t  card_b;

    modport src (output valid, kind, card_a, card_b);
    modport dst (input valid, kind, card_a, card_b);
endinterface

// Raster position and syncs from the timing generator
interface scan_if;
    import memory_game_pkg::*;

    logic   pix_en;
    coord_t h_cnt;
    coord_t v_cnt;
    logic   active;
    logic   hsync;
    logic   vsync;

    modport src (output pix_en, h_cnt, v_cnt, active, hsync, vsync);
    modport dst (input pix_en, h_cnt, v_cnt, active, hsync, vsync);
endinterface

// File: verilog/button_conditioner.sv
`timescale 1ns/1ps

module button_conditioner #(
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    level;
    logic                    level_q;

    // Stable only once every sample agrees
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            level_q <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            samples <= {samples[DEBOUNCE_LEN-2:0], btn_i};
            level_q <= level;
            pulse_o <= level & ~level_q;
        end
    end

endmodule

// File: verilog/key_mapper.sv
`timescale 1ns/1ps

module key_mapper (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   key_valid_i,
    input  memory_game_pkg::scan_t key_code_i,
    key_evt_if.src                 evt
);
    import memory_game_pkg::*;

    logic      is_card;
    card_idx_t card;
    logic      pend_valid;
    card_idx_t pend_card;
    logic      shift_armed;

    always_comb begin
        is_card = 1'b0;
        card    = '0;
        for (int i = 0; i < N_CARDS; i++) begin
            if (key_code_i == CARD_CODES[i]) begin
                is_card = 1'b1;
                card    = card_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            evt.valid   <= 1'b0;
            pend_valid  <= 1'b0;
            shift_armed <= 1'b0;
        end else begin
            evt.valid <= 1'b0;
            if (key_valid_i) begin
                if (key_code_i == CODE_ENTER) begin
                    evt.valid   <= 1'b1;
                    pend_valid  <= 1'b0;
                    shift_armed <= 1'b0;
                end else if (key_code_i == CODE_SHIFT) begin
                    shift_armed <= 1'b1;
                end else if (is_card && shift_armed) begin
                    evt.valid   <= 1'b1;
                    shift_armed <= 1'b0;
                    pend_valid  <= 1'b0;
                end else if (is_card && !pend_valid) begin
                    pend_valid <= 1'b1;
                end else if (is_card && card != pend_card) begin
                    evt.valid  <= 1'b1;
                    pend_valid <= 1'b0;
                end
            end
        end
    end

    // Move payload, qualified by evt.valid
    always_ff @(posedge clk) begin
        if (key_valid_i) begin
            if (key_code_i == CODE_ENTER) begin
                evt.kind <= MOVE_ENTER;
            end else if (is_card && shift_armed) begin
                evt.kind   <= MOVE_FLIP;
                evt.card_a <= card;
            end else if (is_card && !pend_valid) begin
                pend_card <= card;
            end else if (is_card) begin
                evt.kind   <= MOVE_PAIR;
                evt.card_a <= pend_card;
                evt.card_b <= card;
            end
        end
    end

endmodule

// File: verilog/game_controller.sv
`timescale 1ns/1ps

module game_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_pulse_i,
    input  logic                       hint_i,
    key_evt_if.dst                     evt,
    output memory_game_pkg::phase_t    phase_o,
    output memory_game_pkg::card_vec_t shown_o,
    output memory_game_pkg::card_vec_t flipped_o,
    output logic                       pass_o
);
    import memory_game_pkg::*;

    phase_t    phase_q;
    phase_t    next_phase;
    card_vec_t shown_q;
    card_vec_t matched_q;
    card_vec_t flipped_q;
    logic      ready_q;
    logic      hide_pend_q;
    pic_t      pic_a;
    pic_t      pic_b;
    logic      pair_match;

    always_comb begin
        case (phase_q)
            INIT:    next_phase = SHOW;
            SHOW:    next_phase = PLAY;
            PLAY:    next_phase = DONE;
            default: next_phase = INIT;
        endcase
    end

    // Cards i and i+8 carry the same picture
    assign pic_a      = pic_t'(evt.card_a[2:0]);
    assign pic_b      = pic_t'(evt.card_b[2:0]);
    assign pair_match = (pic_a == pic_b) &&
                        (flipped_q[evt.card_a] == flipped_q[evt.card_b]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q     <= INIT;
            shown_q     <= '0;
            matched_q   <= '0;
            flipped_q   <= '0;
            pass_o      <= 1'b0;
            ready_q     <= 1'b1;
            hide_pend_q <= 1'b0;
        end else if (start_pulse_i) begin
            phase_q     <= next_phase;
            ready_q     <= 1'b1;
            hide_pend_q <= 1'b0;
            case (next_phase)
                INIT: begin
                    shown_q   <= '0;
                    matched_q <= '0;
                    flipped_q <= '0;
                    pass_o    <= 1'b0;
                end
                SHOW: begin
                    shown_q   <= '1;
                    matched_q <= '0;
                    flipped_q <= PRESET_FLIP;
                end
                PLAY: begin
                    shown_q <= '0;
                end
                default: begin
                    shown_q <= '1;
                    pass_o  <= 1'b1;
                end
            endcase
        end else if (phase_q == PLAY) begin
            if (hint_i) begin
                shown_q     <= '1;
                hide_pend_q <= 1'b1;
            end else if (hide_pend_q) begin
                // Hint released, matched cards stay up through matched_q
                shown_q     <= '0;
                hide_pend_q <= 1'b0;
            end else if (evt.valid) begin
                case (evt.kind)
                    MOVE_PAIR: if (ready_q) begin
                        shown_q[evt.card_a] <= 1'b1;
                        shown_q[evt.card_b] <= 1'b1;
                        ready_q             <= 1'b0;
                        if (pair_match) begin
                            matched_q[evt.card_a] <= 1'b1;
                            matched_q[evt.card_b] <= 1'b1;
                        end
                    end
                    MOVE_FLIP: if (ready_q) begin
                        flipped_q[evt.card_a] <= ~flipped_q[evt.card_a];
                        shown_q[evt.card_a]   <= 1'b1;
                        ready_q               <= 1'b0;
                    end
                    MOVE_ENTER: if (!ready_q) begin
                        shown_q <= '0;
                        ready_q <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

    assign phase_o   = phase_q;
    assign shown_o   = shown_q | matched_q;
    assign flipped_o = flipped_q;

endmodule

// File: verilog/vga_timing.sv
`timescale 1ns/1ps

module vga_timing #(
    parameter int PIX_DIV = 4
) (
    input  logic clk,
    input  logic rst,
    scan_if.src  scan
);
    import memory_game_pkg::*;

    localparam int DIV_W    = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    logic [DIV_W-1:0] div_cnt;
    coord_t           pixel_cnt;
    coord_t           line_cnt;
    coord_t           pixel_nxt;
    coord_t           line_nxt;

    assign scan.pix_en = (div_cnt == DIV_W'(PIX_DIV - 1));

    always_comb begin
        pixel_nxt = (pixel_cnt == coord_t'(H_TOTAL - 1)) ? '0 : pixel_cnt + 1'b1;
        line_nxt  = line_cnt;
        if (pixel_cnt == coord_t'(H_TOTAL - 1)) begin
            line_nxt = (line_cnt == coord_t'(V_TOTAL - 1)) ? '0 : line_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt    <= '0;
            pixel_cnt  <= '0;
            line_cnt   <= '0;
            scan.hsync <= 1'b1;
            scan.vsync <= 1'b1;
        end else begin
            div_cnt <= scan.pix_en ? '0 : div_cnt + 1'b1;
            if (scan.pix_en) begin
                pixel_cnt <= pixel_nxt;
                line_cnt  <= line_nxt;
                // Syncs follow the counter values they are loaded with
                scan.hsync <= !(pixel_nxt >= HS_START && pixel_nxt < HS_END);
                scan.vsync <= !(line_nxt >= VS_START && line_nxt < VS_END);
            end
        end
    end

    assign scan.active = (pixel_cnt < H_ACTIVE) && (line_cnt < V_ACTIVE);
    assign scan.h_cnt  = (pixel_cnt < H_ACTIVE) ? pixel_cnt : '0;
    assign scan.v_cnt  = (line_cnt < V_ACTIVE) ? line_cnt : '0;

endmodule

// File: verilog/tile_renderer.sv
`timescale 1ns/1ps

module tile_renderer (
    input  logic                       clk,
    input  logic                       rst,
    scan_if.dst                        scan,
    input  memory_game_pkg::card_vec_t shown_i,
    input  memory_game_pkg::card_vec_t flipped_i,
    output memory_game_pkg::rgb_t      rgb_o,
    output logic                       hsync_o,
    output logic                       vsync_o
);
    import memory_game_pkg::*;

    coord_t    x;
    coord_t    y;
    logic [1:0] col;
    logic [1:0] row;
    logic [5:0] tile_row;
    card_idx_t idx;
    pic_t      pic;
    logic      lit;
    rgb_t      colour;

    // Half resolution, 320x240 split into a 4x4 grid
    assign x        = scan.h_cnt >> 1;
    assign y        = scan.v_cnt >> 1;
    assign col      = 2'(x / TILE_W);
    assign row      = 2'(y / TILE_H);
    assign tile_row = 6'(y % TILE_H);
    assign idx      = card_idx_t'(row * GRID_DIM + col);
    assign pic      = pic_t'(idx[2:0]);

    // Upright cards use the top half, flipped ones the bottom half
    assign lit = flipped_i[idx] ? (tile_row >= TILE_H / 2) : (tile_row < TILE_H / 2);

    assign colour = (scan.active && shown_i[idx] && lit) ? PALETTE[pic] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rgb_o   <= '0;
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else if (scan.pix_en) begin
            rgb_o   <= colour;
            hsync_o <= scan.hsync;
            vsync_o <= scan.vsync;
        end
    end

endmodule

// File: verilog/memory_game_top.sv
`timescale 1ns/1ps

module memory_game_top #(
    parameter int PIX_DIV      = 4,
    parameter int DEBOUNCE_LEN = 7
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_i,
    input  logic                       hint_i,
    input  logic                       key_valid_i,
    input  memory_game_pkg::scan_t     key_code_i,
    output logic [3:0]                 vga_r_o,
    output logic [3:0]                 vga_g_o,
    output logic [3:0]                 vga_b_o,
    output logic                       hsync_o,
    output logic                       vsync_o,
    output memory_game_pkg::phase_t    phase_o,
    output memory_game_pkg::card_vec_t shown_o,
    output logic                       pass_o
);
    import memory_game_pkg::*;

    logic      start_pulse;
    card_vec_t shown;
    card_vec_t flipped;
    rgb_t      rgb;

    key_evt_if evt_bus ();
    scan_if    scan_bus ();

    button_conditioner #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) button_conditioner_inst (
        .clk    (clk),
        .rst    (rst),
        .btn_i  (start_i),
        .pulse_o(start_pulse)
    );

    key_mapper key_mapper_inst (
        .clk        (clk),
        .rst        (rst),
        .key_valid_i(key_valid_i),
        .key_code_i (key_code_i),
        .evt        (evt_bus.src)
    );

    game_controller game_controller_inst (
        .clk          (clk),
        .rst          (rst),
        .start_pulse_i(start_pulse),
        .hint_i       (hint_i),
        .evt          (evt_bus.dst),
        .phase_o      (phase_o),
        .shown_o      (shown),
        .flipped_o    (flipped),
        .pass_o       (pass_o)
    );

    vga_timing #(.PIX_DIV(PIX_DIV)) vga_timing_inst (
        .clk (clk),
        .rst (rst),
        .scan(scan_bus.src)
    );

    tile_renderer tile_renderer_inst (
        .clk      (clk),
        .rst      (rst),
        .scan     (scan_bus.dst),
        .shown_i  (shown),
        .flipped_i(flipped),
        .rgb_o    (rgb),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o)
    );

    assign shown_o = shown;
    assign vga_r_o = rgb.r;
    assign vga_g_o = rgb.g;
    assign vga_b_o = rgb.b;

endmodule

// File: verification/memory_game_assert.sv
`timescale 1ns/1ps

module memory_game_assert (
    input logic                    clk,
    input logic                    rst,
    input logic                    hsync,
    input memory_game_pkg::coord_t pixel_cnt,
    input memory_game_pkg::coord_t h_cnt,
    input logic                    evt_valid
);
    import memory_game_pkg::*;

    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;

    int fail_cnt;

    initial fail_cnt = 0;

    hsync_window: assert property (@(posedge clk) disable iff (rst)
        !hsync |-> (pixel_cnt >= HS_START && pixel_cnt < HS_END))
        else begin
            fail_cnt++;
            $error("hsync low outside the sync window");
        end

    h_cnt_range: assert property (@(posedge clk) disable iff (rst) h_cnt < H_ACTIVE)
        else begin
            fail_cnt++;
            $error("scan h_cnt beyond the active width");
        end

    evt_single: assert property (@(posedge clk) disable iff (rst) evt_valid |=> !evt_valid)
        else begin
            fail_cnt++;
            $error("event strobe held for two cycles");
        end

endmodule

// Sync checks on the timing generator, strobe check on the key decoder
bind vga_timing memory_game_assert scan_checks (
    .clk(clk), .rst(rst), .hsync(scan.hsync), .pixel_cnt(pixel_cnt),
    .h_cnt(scan.h_cnt), .evt_valid(1'b0)
);

bind key_mapper memory_game_assert evt_checks (
    .clk(clk), .rst(rst), .hsync(1'b1), .pixel_cnt('0), .h_cnt('0), .evt_valid(evt.valid)
);

// File: verification/memory_game_tb.sv
`timescale 1ns/1ps

module memory_game_tb;
    import memory_game_pkg::*;

    localparam int HS_END = H_ACTIVE + H_FRONT + H_SYNC;
    localparam int VS_END = V_ACTIVE + V_FRONT + V_SYNC;

    logic       clk;
    logic       rst;
    logic       start_i;
    logic       hint_i;
    logic       key_valid_i;
    scan_t      key_code_i;
    logic [3:0] vga_r_o;
    logic [3:0] vga_g_o;
    logic [3:0] vga_b_o;
    logic       hsync_o;
    logic       vsync_o;
    phase_t     phase_o;
    card_vec_t  shown_o;
    logic       pass_o;

    // Expected game state
    phase_t      exp_phase;
    logic        exp_pass;
    card_vec_t   m_raw;
    card_vec_t   m_matched;
    card_vec_t   m_flipped;
    logic        m_ready;
    rgb_t        exp_rgb;
    logic        pix_mode;
    int          checks;
    int          errors;
    int          test_err0;
    int          n_rise;
    logic        prev_hs;
    int unsigned seed;
    event        check_ev;
    event        check_done;

    memory_game_top #(.PIX_DIV(1), .DEBOUNCE_LEN(7)) memory_game_top_inst (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start_i),
        .hint_i     (hint_i),
        .key_valid_i(key_valid_i),
        .key_code_i (key_code_i),
        .vga_r_o    (vga_r_o),
        .vga_g_o    (vga_g_o),
        .vga_b_o    (vga_b_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o),
        .phase_o    (phase_o),
        .shown_o    (shown_o),
        .pass_o     (pass_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic ref_match(card_idx_t a, card_idx_t b, card_vec_t flips);
        return (a % 8 == b % 8) && (flips[a] == flips[b]);
    endfunction

    function automatic card_vec_t ref_visible(card_vec_t raw, card_vec_t matched);
        return raw | matched;
    endfunction

    function automatic rgb_t ref_pixel(int p, int l, card_vec_t shown, card_vec_t flips);
        int y;
        int idx;
        int tile_row;
        if (p >= H_ACTIVE || l >= V_ACTIVE) return '0;
        y        = l / 2;
        idx      = (y / TILE_H) * GRID_DIM + (p / 2) / TILE_W;
        tile_row = y % TILE_H;
        if (!shown[idx]) return '0;
        // Flipped tiles light the lower half
        if (flips[idx] != (tile_row >= TILE_H / 2)) return '0;
        return PALETTE[idx % 8];
    endfunction

    always begin
        @(check_ev);
        checks++;
        if (pix_mode) begin
            if ({vga_r_o, vga_g_o, vga_b_o} != exp_rgb) begin
                errors++;
                $display("error t=%0t rgb_o got %h expected %h", $time,
                         {vga_r_o, vga_g_o, vga_b_o}, exp_rgb);
            end
        end else begin
            if (phase_o != exp_phase) begin
                errors++;
                $display("error t=%0t phase_o got %0d expected %0d", $time, phase_o, exp_phase);
            end
            if (shown_o != ref_visible(m_raw, m_matched)) begin
                errors++;
                $display("error t=%0t shown_o got %h expected %h", $time, shown_o,
                         ref_visible(m_raw, m_matched));
            end
            if (pass_o != exp_pass) begin
                errors++;
                $display("error t=%0t pass_o got %b expected %b", $time, pass_o, exp_pass);
            end
            if (rst && {hsync_o, vsync_o} != 2'b11) begin
                errors++;
                $display("error t=%0t hsync_o/vsync_o got %b expected 11", $time,
                         {hsync_o, vsync_o});
            end
        end
        -> check_done;
    end

    task automatic abort_timeout(string what);
        $display("timeout while waiting for %s at %0t", what, $time);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic check_state();
        @(negedge clk);
        pix_mode = 1'b0;
        -> check_ev;
        @(check_done);
    endtask

    task automatic finish_test(string name);
        $display("test %-7s %s, %0d errors", name, (errors == test_err0) ? "ok" : "failed",
                 errors - test_err0);
        test_err0 = errors;
    endtask

    task automatic send_key(scan_t code);
        @(posedge clk);
        key_valid_i <= 1'b1;
        key_code_i  <= code;
        @(posedge clk);
        key_valid_i <= 1'b0;
        // Decode, then controller update
        repeat (2) @(posedge clk);
    endtask

    task automatic step_phase();
        phase_t old;
        int     n;
        old = phase_o;
        n   = 0;
        @(posedge clk);
        start_i <= 1'b1;
        while (phase_o == old) begin
            @(negedge clk);
            n++;
            if (n > 40) abort_timeout("the phase to step");
        end
        repeat (12) @(posedge clk);
        start_i <= 1'b0;
        repeat (12) @(posedge clk);
        case (exp_phase)
            INIT: begin
                exp_phase = SHOW;
                m_raw     = '1;
                m_matched = '0;
                m_flipped = PRESET_FLIP;
            end
            SHOW: begin
                exp_phase = PLAY;
                m_raw     = '0;
            end
            PLAY: begin
                exp_phase = DONE;
                m_raw     = '1;
                exp_pass  = 1'b1;
            end
            default: begin
                exp_phase = INIT;
                m_raw     = '0;
                m_matched = '0;
                m_flipped = '0;
                exp_pass  = 1'b0;
            end
        endcase
        m_ready = 1'b1;
        check_state();
    endtask

    task automatic do_pair(card_idx_t a, card_idx_t b);
        send_key(CARD_CODES[a]);
        send_key(CARD_CODES[b]);
        if (m_ready) begin
            m_raw[a] = 1'b1;
            m_raw[b] = 1'b1;
            m_ready  = 1'b0;
            if (ref_match(a, b, m_flipped)) begin
                m_matched[a] = 1'b1;
                m_matched[b] = 1'b1;
            end
        end
        check_state();
    endtask

    task automatic do_flip(card_idx_t c);
        send_key(CODE_SHIFT);
        send_key(CARD_CODES[c]);
        if (m_ready) begin
            m_flipped[c] = ~m_flipped[c];
            m_raw[c]     = 1'b1;
            m_ready      = 1'b0;
        end
        check_state();
    endtask

    task automatic press_enter();
        send_key(CODE_ENTER);
        if (!m_ready) begin
            m_raw   = '0;
            m_ready = 1'b1;
        end
        check_state();
    endtask

    task automatic hold_hint();
        int n;
        n = 0;
        @(posedge clk);
        hint_i <= 1'b1;
        while (shown_o != '1) begin
            @(negedge clk);
            n++;
            if (n > 20) abort_timeout("hint to show all cards");
        end
        m_raw = '1;
        check_state();
        @(posedge clk);
        hint_i <= 1'b0;
        m_raw = '0;
        n     = 0;
        while (shown_o != ref_visible(m_raw, m_matched)) begin
            @(negedge clk);
            n++;
            if (n > 20) abort_timeout("unmatched cards to hide");
        end
        check_state();
    endtask

    task automatic next_pixel();
        @(negedge clk);
        if (!prev_hs && hsync_o) n_rise++;
        prev_hs = hsync_o;
    endtask

    task automatic compare_pixel(int p, int l);
        pix_mode = 1'b1;
        exp_rgb  = ref_pixel(p, l, ref_visible(m_raw, m_matched), m_flipped);
        -> check_ev;
        @(check_done);
    endtask

    task automatic scan_pixels();
        int   lines [8];
        int   guard;
        int   target;
        int   p;
        int   t;
        int   k;
        logic prev_vs;
        lines   = '{500, 10, 90, 130, 250, 310, 400, 470};
        guard   = 0;
        prev_vs = 1'b1;
        // A rising vsync is pixel 0 of line VS_END
        while (prev_vs || !vsync_o) begin
            prev_vs = vsync_o;
            @(negedge clk);
            guard++;
            if (guard > 2 * H_TOTAL * V_TOTAL) abort_timeout("a vsync edge");
        end
        n_rise  = 0;
        prev_hs = hsync_o;
        for (t = 0; t < 8; t++) begin
            // Rise n is pixel HS_END of line VS_END + n - 1
            target = (lines[t] - VS_END + V_TOTAL) % V_TOTAL;
            guard  = 0;
            while (n_rise < target) begin
                next_pixel();
                guard++;
                if (guard > H_TOTAL * V_TOTAL) abort_timeout("an hsync edge");
            end
            for (k = 0; k < H_TOTAL; k++) begin
                if (k > 0) next_pixel();
                p = (HS_END + k) % H_TOTAL;
                compare_pixel(p, (p >= HS_END) ? lines[t] - 1 : lines[t]);
            end
        end
        pix_mode = 1'b0;
    endtask

    initial begin
        card_idx_t a;
        card_idx_t b;
        int        assert_fails;
        seed        = $urandom(32'h09493311);
        rst         = 1'b1;
        start_i     = 1'b0;
        hint_i      = 1'b0;
        key_valid_i = 1'b0;
        key_code_i  = '0;
        exp_phase   = INIT;
        exp_pass    = 1'b0;
        m_raw       = '0;
        m_matched   = '0;
        m_flipped   = '0;
        m_ready     = 1'b1;
        pix_mode    = 1'b0;
        checks      = 0;
        errors      = 0;
        test_err0   = 0;
        repeat (4) @(posedge clk);
        check_state();
        compare_pixel(H_ACTIVE, 0);
        @(posedge clk);
        rst <= 1'b0;
        finish_test("reset");

        step_phase();
        step_phase();
        finish_test("phases");

        for (int i = 0; i < 12; i++) begin
            a = card_idx_t'($urandom % N_CARDS);
            if ($urandom % 2) b = a ^ 4'd8;
            else b = card_idx_t'((a + 1 + $urandom % (N_CARDS - 1)) % N_CARDS);
            do_pair(a, b);
            press_enter();
        end
        finish_test("pairs");

        do_flip(0);
        press_enter();
        do_pair(0, 8);
        press_enter();
        do_flip(5);
        press_enter();
        do_pair(13, 5);
        press_enter();
        do_flip(3);
        press_enter();
        do_pair(3, 11);
        press_enter();
        finish_test("flips");

        // An unmatched pair is face up when the hint goes on
        do_pair(2, 7);
        hold_hint();
        press_enter();
        finish_test("hint");

        scan_pixels();
        finish_test("pixels");

        step_phase();
        step_phase();
        finish_test("wrap");

        assert_fails = memory_game_top_inst.vga_timing_inst.scan_checks.fail_cnt
                     + memory_game_top_inst.key_mapper_inst.evt_checks.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
                 assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
verilog/memory_game_pkg.sv
verilog/game_ifs.sv
verilog/button_conditioner.sv
verilog/key_mapper.sv
verilog/game_controller.sv
verilog/vga_timing.sv
verilog/tile_renderer.sv
verilog/memory_game_top.sv
verification/memory_game_assert.sv
verification/memory_game_tb.sv

// File: Bender.yml
package:
  name: memory_game

sources:
  - files:
      - verilog/memory_game_pkg.sv
      - verilog/game_ifs.sv
      - verilog/button_conditioner.sv
      - verilog/key_mapper.sv
      - verilog/game_controller.sv
      - verilog/vga_timing.sv
      - verilog/tile_renderer.sv
      - verilog/memory_game_top.sv
  - target: test
    files:
      - verification/memory_game_assert.sv
      - verification/memory_game_tb.sv
